/* design/pool_pkg.sv */
package pool_pkg;

	// ----------------------------------------------------------------------
	// word and field widths
	// ----------------------------------------------------------------------
	localparam int WORD_W    = 32;  // host pipe word
	localparam int SAMPLE_W  = 16;  // low half of a sample word, unsigned
	localparam int WIN_LOG_W = 4;   // window_log field, bits 3..0 of a command

	// op_type sits in the top three bits of a command word
	localparam int OP_TYPE_MSB = 31;
	localparam int OP_TYPE_LSB = 29;

	// ----------------------------------------------------------------------
	// opcodes and control states
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		CONV    = 3'd0,  // recognised, no engine behind it
		MAXPOOL = 3'd1,
		AVEPOOL = 3'd2
	} op_type_e;

	typedef enum logic [1:0] {
		CSB_IDLE   = 2'd0,  // waiting for a command word
		CSB_RUN    = 2'd1,  // feeding samples to the core
		CSB_RESULT = 2'd2   // holding the result for the router
	} csb_state_e;

endpackage

/* design/pipe_link_if.sv */
`timescale 1ns/100ps

interface pipe_link_if;
	import pool_pkg::*;

	logic              in_pop;    // remove head of pipe-in
	logic [WORD_W-1:0] in_data;   // head of pipe-in, valid while !in_empty
	logic              in_empty;
	logic              out_push;  // write out_data into pipe-out
	logic [WORD_W-1:0] out_data;
	logic              out_full;

	modport pipes (
		input  in_pop, out_push, out_data,
		output in_data, in_empty, out_full
	);

	modport router (
		input  in_data, in_empty, out_full,
		output in_pop, out_push, out_data
	);

endinterface

/* design/pool_if.sv */
`timescale 1ns/100ps

interface pool_if;
	import pool_pkg::*;

	logic                 clear;    // start of a window
	logic                 acc_en;   // take one sample
	logic [SAMPLE_W-1:0]  sample;
	op_type_e             op;
	logic [WIN_LOG_W-1:0] win_log;
	logic [SAMPLE_W-1:0]  result;   // valid the cycle after the last acc_en

	modport ctrl (
		output clear, acc_en, sample, op, win_log,
		input  result
	);

	modport core (
		input  clear, acc_en, sample, op, win_log,
		output result
	);

endinterface

/* design/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
	parameter int DEPTH = 1024
) (
	input  logic                             okClk,
	input  logic                             rst,
	input  logic                             push,
	input  logic [pool_pkg::WORD_W-1:0]      push_data,
	output logic                             full,
	input  logic                             pop,
	output logic [pool_pkg::WORD_W-1:0]      pop_data,
	output logic                             empty,
	output logic [$clog2(DEPTH+1)-1:0]       count
);
	import pool_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic [WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0]     wr_ptr, rd_ptr;
	logic              do_push, do_pop;

	assign full     = (count == DEPTH);
	assign empty    = (count == 0);
	assign do_push  = push & ~full;   // writes into a full fifo are dropped
	assign do_pop   = pop & ~empty;
	assign pop_data = mem[rd_ptr];    // first word falls through

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* design/host_pipes.sv */
`timescale 1ns/100ps

module host_pipes #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,
	parameter int BUFFER_HEADROOM = 20
) (
	input  logic                        okClk,
	input  logic                        rst,
	input  logic                        pipe_in_write,
	input  logic [pool_pkg::WORD_W-1:0] pipe_in_data,
	input  logic                        pipe_out_read,
	output logic [pool_pkg::WORD_W-1:0] pipe_out_data,
	output logic                        pipe_out_empty,
	output logic                        pipe_in_ready,
	output logic                        pipe_out_ready,
	pipe_link_if.pipes                  link
);

	localparam int CNT_W     = $clog2(FIFO_DEPTH + 1);
	localparam int IN_THRESH = FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE;

	logic [CNT_W-1:0] in_count, out_count;

	sync_fifo #(.DEPTH(FIFO_DEPTH)) pipe_in_fifo (
		.okClk     (okClk),
		.rst       (rst),
		.push      (pipe_in_write),   // host side
		.push_data (pipe_in_data),
		.full      (),
		.pop       (link.in_pop),     // router side
		.pop_data  (link.in_data),
		.empty     (link.in_empty),
		.count     (in_count)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH)) pipe_out_fifo (
		.okClk     (okClk),
		.rst       (rst),
		.push      (link.out_push),
		.push_data (link.out_data),
		.full      (link.out_full),
		.pop       (pipe_out_read),
		.pop_data  (pipe_out_data),
		.empty     (pipe_out_empty),
		.count     (out_count)
	);

	// ----------------------------------------------------------------------
	// block throttle, room for one more block in, a whole block out
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= (in_count <= IN_THRESH);   // headroom covers count lag
			pipe_out_ready <= (out_count >= BLOCK_SIZE);
		end
	end

endmodule

/* design/word_router.sv */
`timescale 1ns/100ps

module word_router (
	input  logic                        okClk,
	input  logic                        rst,
	input  logic                        op_en,
	pipe_link_if.router                 link,
	output logic                        word_valid,
	input  logic                        word_ready,
	output logic [pool_pkg::WORD_W-1:0] word_data,
	input  logic                        res_valid,
	output logic                        res_ready,
	input  logic [pool_pkg::WORD_W-1:0] res_data,
	output logic                        irq
);

	logic loop_move;   // loopback word moves this cycle
	logic res_fire;    // result enters pipe-out this cycle

	assign loop_move = ~op_en & ~link.in_empty & ~link.out_full;

	// pool stream, pipe-in head offered straight to the control block
	assign word_valid = op_en & ~link.in_empty;
	assign word_data  = link.in_data;
	assign res_ready  = op_en & ~link.out_full;
	assign res_fire   = res_valid & res_ready;

	assign link.in_pop   = loop_move | (word_valid & word_ready);
	assign link.out_push = loop_move | res_fire;
	assign link.out_data = op_en ? res_data : link.in_data;

	always_ff @(posedge okClk) begin
		if (rst) begin
			irq <= 1'b0;
		end else begin
			irq <= res_fire;   // one pulse per result
		end
	end

endmodule

/* design/pool_csb.sv */
`timescale 1ns/100ps

module pool_csb (
	input  logic                        okClk,
	input  logic                        rst,
	input  logic                        word_valid,
	output logic                        word_ready,
	input  logic [pool_pkg::WORD_W-1:0] word_data,
	output logic                        res_valid,
	input  logic                        res_ready,
	output logic [pool_pkg::WORD_W-1:0] res_data,
	pool_if.ctrl                        pool
);
	import pool_pkg::*;

	localparam int CNT_W = 2**WIN_LOG_W;   // holds up to 2**15 sample indices

	csb_state_e           state;
	op_type_e             cmd_op;
	op_type_e             op_q;
	logic [WIN_LOG_W-1:0] win_log_q;
	logic [CNT_W-1:0]     cnt, last_idx;
	logic                 word_fire, cmd_ok;

	// ----------------------------------------------------------------------
	// command decode and core drive
	// ----------------------------------------------------------------------
	assign cmd_op    = op_type_e'(word_data[OP_TYPE_MSB:OP_TYPE_LSB]);
	assign cmd_ok    = (cmd_op == MAXPOOL) || (cmd_op == AVEPOOL);   // CONV and others dropped
	assign word_fire = word_valid & word_ready;
	assign last_idx  = (CNT_W'(1) << win_log_q) - 1'b1;

	assign word_ready   = (state != CSB_RESULT);   // one word per cycle otherwise
	assign pool.clear   = (state == CSB_IDLE) & word_fire & cmd_ok;
	assign pool.acc_en  = (state == CSB_RUN) & word_fire;
	assign pool.sample  = word_data[SAMPLE_W-1:0];
	assign pool.op      = op_q;
	assign pool.win_log = win_log_q;

	assign res_valid = (state == CSB_RESULT);
	assign res_data  = {{(WORD_W - SAMPLE_W){1'b0}}, pool.result};   // upper half zero

	always_ff @(posedge okClk) begin
		if (pool.clear) begin
			op_q      <= cmd_op;
			win_log_q <= word_data[WIN_LOG_W-1:0];
		end
	end

	// ----------------------------------------------------------------------
	// window sequencing
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			state <= CSB_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				CSB_IDLE: begin
					cnt <= '0;
					if (pool.clear) begin
						state <= CSB_RUN;
					end
				end
				CSB_RUN: begin
					if (pool.acc_en) begin
						cnt <= cnt + 1'b1;
						if (cnt == last_idx) begin
							state <= CSB_RESULT;   // core result settles next cycle
						end
					end
				end
				CSB_RESULT: begin
					if (res_ready) begin
						state <= CSB_IDLE;
					end
				end
				default: state <= CSB_IDLE;
			endcase
		end
	end

endmodule

/* design/pool_core.sv */
`timescale 1ns/100ps

module pool_core (
	input  logic okClk,
	input  logic rst,
	pool_if.core pool
);
	import pool_pkg::*;

	// widest window is 2**15 samples of SAMPLE_W bits
	localparam int SUM_W = SAMPLE_W + 2**WIN_LOG_W - 1;

	logic [SAMPLE_W-1:0] max_q;
	logic [SUM_W-1:0]    sum_q;
	logic [SUM_W-1:0]    sum_shift;

	// ----------------------------------------------------------------------
	// running max and sum over one window
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || pool.clear) begin
			max_q <= '0;   // samples are unsigned
			sum_q <= '0;
		end else if (pool.acc_en) begin
			if (pool.sample > max_q) begin
				max_q <= pool.sample;
			end
			sum_q <= sum_q + SUM_W'(pool.sample);
		end
	end

	// average of a power-of-two window is a plain shift
	assign sum_shift = sum_q >> pool.win_log;

	assign pool.result = (pool.op == MAXPOOL) ? max_q : sum_shift[SAMPLE_W-1:0];

endmodule

/* design/squeeze_host_top.sv */
`timescale 1ns/100ps

module squeeze_host_top #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,
	parameter int BUFFER_HEADROOM = 20
) (
	input  logic                        okClk,
	input  logic                        rst,
	input  logic                        op_en,          // 0 loopback, 1 pooling
	input  logic                        pipe_in_write,
	input  logic [pool_pkg::WORD_W-1:0] pipe_in_data,
	output logic                        pipe_in_ready,
	input  logic                        pipe_out_read,
	output logic [pool_pkg::WORD_W-1:0] pipe_out_data,
	output logic                        pipe_out_empty,
	output logic                        pipe_out_ready,
	output logic                        irq             // one pulse per pool result
);
	import pool_pkg::*;

	logic              word_valid, word_ready;
	logic [WORD_W-1:0] word_data;
	logic              res_valid, res_ready;
	logic [WORD_W-1:0] res_data;

	pipe_link_if link ();
	pool_if      pool ();

	host_pipes #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BLOCK_SIZE      (BLOCK_SIZE),
		.BUFFER_HEADROOM (BUFFER_HEADROOM)
	) u_host_pipes (
		.okClk (okClk), .rst (rst),
		.pipe_in_write (pipe_in_write), .pipe_in_data (pipe_in_data),
		.pipe_out_read (pipe_out_read), .pipe_out_data (pipe_out_data),
		.pipe_out_empty (pipe_out_empty),
		.pipe_in_ready (pipe_in_ready), .pipe_out_ready (pipe_out_ready),
		.link (link.pipes)
	);

	word_router u_word_router (
		.okClk (okClk), .rst (rst), .op_en (op_en), .link (link.router),
		.word_valid (word_valid), .word_ready (word_ready), .word_data (word_data),
		.res_valid (res_valid), .res_ready (res_ready), .res_data (res_data),
		.irq (irq)
	);

	pool_csb u_pool_csb (
		.okClk (okClk), .rst (rst),
		.word_valid (word_valid), .word_ready (word_ready), .word_data (word_data),
		.res_valid (res_valid), .res_ready (res_ready), .res_data (res_data),
		.pool (pool.ctrl)
	);

	pool_core u_pool_core (
		.okClk (okClk), .rst (rst), .pool (pool.core)
	);

endmodule

/* sim/tb_pool_model.svh */
`ifndef TB_POOL_MODEL_SVH
`define TB_POOL_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};   // one step per bit taken
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

// reference pooling over win[0..n-1], upper half of the word zero
function automatic logic [31:0] max_ref(input int n);
	logic [15:0] m;
	m = '0;
	for (int i = 0; i < n; i++) begin
		if (win[i] > m) begin
			m = win[i];
		end
	end
	return {16'h0, m};
endfunction

function automatic logic [31:0] ave_ref(input int n, input int log2n);
	logic [31:0] sum;
	sum = '0;
	for (int i = 0; i < n; i++) begin
		sum = sum + win[i];
	end
	sum = sum >> log2n;
	return {16'h0, sum[15:0]};
endfunction

// called and returning 5 ns after a rising edge
task automatic write_word(input logic [31:0] word);
	while (!pipe_in_ready) begin
		@(posedge okClk);
		#5;
	end
	pipe_in_write = 1'b1;
	pipe_in_data  = word;
	@(posedge okClk);
	#5;
	pipe_in_write = 1'b0;
endtask

// pop the pipe-out head and compare it with the oldest expected word
task automatic pop_and_check();
	logic [31:0] exp_w;
	assert (exp_q.size() != 0) else begin
		$display("pipe-out gave word %h with nothing expected in %s", pipe_out_data, test_name);
		other_errs++;
	end
	if (exp_q.size() != 0) begin
		exp_w = exp_q.pop_front();
		assert (pipe_out_data === exp_w) else begin
			$display("FAIL %s expected %h actual %h", test_name, exp_w, pipe_out_data);
			value_errs++;
		end
	end
	pipe_out_read = 1'b1;
endtask

`endif

/* sim/tb_squeeze_host.sv */
`timescale 1ns/100ps

module tb_squeeze_host;
	import pool_pkg::*;

	localparam int FIFO_DEPTH      = 32;
	localparam int BLOCK_SIZE      = 8;
	localparam int BUFFER_HEADROOM = 4;
	localparam int IN_THRESH       = FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE;
	localparam int CLK_PERIOD      = 100;
	localparam int TOTAL_WORDS     = 40 + 2 * FIFO_DEPTH + 53 + 102 + 11;   // all tests
	localparam int LIMIT_CYCLES    = TOTAL_WORDS * 4 + 2000;

	logic        okClk = 1'b0;
	logic        rst, op_en, irq;
	logic        pipe_in_write, pipe_in_ready, pipe_out_read, pipe_out_empty, pipe_out_ready;
	logic [31:0] pipe_in_data, pipe_out_data;

	logic [31:0] lfsr_state, w;
	logic [31:0] exp_q [$];            // expected pipe-out words in order
	logic [15:0] win [0:15];           // samples of the current window
	logic        reads_on, exp_flag;
	string       test_name;
	int          value_errs, other_errs, res_count, irq_count, written;

	`include "tb_pool_model.svh"

	always #(CLK_PERIOD / 2) okClk = ~okClk;

	squeeze_host_top #(
		.FIFO_DEPTH (FIFO_DEPTH), .BLOCK_SIZE (BLOCK_SIZE), .BUFFER_HEADROOM (BUFFER_HEADROOM)
	) u_squeeze_host_top (
		.okClk (okClk), .rst (rst), .op_en (op_en), .irq (irq),
		.pipe_in_write (pipe_in_write), .pipe_in_data (pipe_in_data),
		.pipe_in_ready (pipe_in_ready), .pipe_out_read (pipe_out_read),
		.pipe_out_data (pipe_out_data), .pipe_out_empty (pipe_out_empty),
		.pipe_out_ready (pipe_out_ready)
	);

	task automatic send_window(input logic [2:0] op, input int log2n);
		logic [31:0] s;
		write_word({op, 25'h0, log2n[3:0]});   // command word
		for (int i = 0; i < (1 << log2n); i++) begin
			rand_bits(32, s);
			win[i] = s[15:0];
			write_word(s);
		end
		exp_q.push_back((op == MAXPOOL) ? max_ref(1 << log2n) : ave_ref(1 << log2n, log2n));
		res_count++;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || !pipe_out_empty) begin
			@(posedge okClk);
			#5;
		end
	endtask

	task automatic check_irq();
		repeat (3) @(posedge okClk);
		#5;
		assert (irq_count == res_count) else begin
			$display("FAIL %s irq pulses expected %0d actual %0d", test_name, res_count, irq_count);
			value_errs++;
		end
	endtask

	// ----------------------------------------------------------------------
	// scoreboard, irq counter and watchdog
	// ----------------------------------------------------------------------
	always begin
		@(posedge okClk);
		#5;
		pipe_out_read = 1'b0;
		if (!rst && reads_on && !pipe_out_empty) begin
			pop_and_check();
		end
	end

	always @(negedge okClk) begin
		if (!rst && irq === 1'b1) begin
			irq_count++;
		end
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("timeout, tests did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		rst           = 1'b1;
		op_en         = 1'b0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		reads_on      = 1'b1;
		lfsr_state    = 32'd37;
		test_name     = "reset";
		repeat (16) @(posedge okClk);
		#5;
		rst = 1'b0;
		assert (pipe_in_ready === 1'b0) else begin
			$display("FAIL %s pipe_in_ready expected 0 actual %b", test_name, pipe_in_ready);
			value_errs++;
		end
		@(posedge okClk);
		#5;
		assert ({pipe_out_empty, irq, pipe_out_ready, pipe_in_ready} === 4'b1001) else begin
			$display("FAIL %s flags expected 1001 actual %b%b%b%b", test_name,
				pipe_out_empty, irq, pipe_out_ready, pipe_in_ready);
			value_errs++;
		end

		test_name = "loopback";
		for (int i = 0; i < 40; i++) begin
			rand_bits(32, w);
			exp_q.push_back(w);
			write_word(w);
		end
		wait_drained();

		test_name = "throttle";
		reads_on  = 1'b0;
		written   = 0;
		while (pipe_in_ready && written < 2 * FIFO_DEPTH) begin
			rand_bits(32, w);
			exp_q.push_back(w);
			write_word(w);
			written++;
		end
		repeat (10) @(posedge okClk);
		#5;
		if (written <= FIFO_DEPTH) begin
			exp_flag = (written >= BLOCK_SIZE);
			assert (pipe_out_ready === exp_flag) else begin
				$display("FAIL %s pipe_out_ready expected %b actual %b", test_name,
					exp_flag, pipe_out_ready);
				value_errs++;
			end
		end else begin
			exp_flag = (written - FIFO_DEPTH <= IN_THRESH);   // words left in pipe-in
			assert (pipe_in_ready === exp_flag && pipe_out_ready === 1'b1) else begin
				$display("FAIL %s in/out ready expected %b1 actual %b%b", test_name,
					exp_flag, pipe_in_ready, pipe_out_ready);
				value_errs++;
			end
		end
		reads_on = 1'b1;
		wait_drained();
		check_irq();

		op_en     = 1'b1;   // pool mode, everything drained and idle
		test_name = "maxpool";
		for (int k = 0; k <= 4; k++) begin
			send_window(MAXPOOL, k);
		end
		send_window(MAXPOOL, 4);
		wait_drained();
		check_irq();

		test_name = "avepool";
		for (int k = 0; k < 6; k++) begin
			rand_bits(3, w);
			send_window(AVEPOOL, w % 5);
		end
		wait_drained();
		check_irq();

		test_name = "unsupported";
		write_word({CONV, 25'h0, 4'd3});
		write_word({3'd6, 25'h0, 4'd1});
		send_window(MAXPOOL, 3);
		wait_drained();
		check_irq();

		$display("checks failed: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+sim
design/pool_pkg.sv
design/pipe_link_if.sv
design/pool_if.sv
design/sync_fifo.sv
design/host_pipes.sv
design/word_router.sv
design/pool_csb.sv
design/pool_core.sv
design/squeeze_host_top.sv
sim/tb_squeeze_host.sv
